/* vlog.f */
design/regfile_pkg.sv
design/regfile_if.sv
design/tag_slot.sv
design/gpr_bank.sv
design/mmx_bank.sv
design/regfile_top.sv
test/regfile_props.sv
test/regfile_tb.sv

/* test/regfile_tb.sv */
`timescale 1ns/1ps

module regfile_tb import regfile_pkg::*; ();

    localparam int clk_period     = 100;
    localparam int rst_cycles     = 8;
    localparam int sweep_cycles   = 4 * num_regs; // every size at every address
    localparam int num_cycles     = 2000;
    localparam int timeout_cycles = rst_cycles + sweep_cycles + num_cycles + 60;

    logic                 clk;
    logic                 rst;
    logic                 wr_en;
    reg_addr_t            wr_addr;
    size_e                wr_size;
    data_t                wr_data;
    reg_addr_t            rd_addr;
    size_e                rd_size;
    logic                 dest;
    tag_t                 new_tag;
    tag_t                 bcast_tag;
    logic                 flush;
    data_t                rd_data;
    logic [num_slots-1:0] rd_busy;
    tag_t                 rd_tag0;
    tag_t                 rd_tag1;
    tag_t                 rd_tag2;

    // reference model, byte images plus per-section tag state
    logic [7:0] gpr_img  [num_regs][4];
    data_t      mmx_img  [num_regs];
    tag_t       sec_tag  [num_regs][3];
    logic       sec_busy [num_regs][3];
    tag_t       mm_tag   [num_regs];
    logic       mm_busy  [num_regs];

    data_t                exp_data;
    logic [num_slots-1:0] exp_busy;
    tag_t                 exp_tag [num_slots];

    tag_t        recent_tags [$];
    int          err_count;

    regfile_top regfile_top_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    // true when an access at addr/size covers section s of general register r
    function automatic logic section_hit(input reg_addr_t addr, input size_e size,
                                         input int r, input int s);
        case (size)
            size_8:  return (addr < 4) ? (int'(addr) == r && s == 0)
                                       : (int'(addr) - 4 == r && s == 1);
            size_16: return int'(addr) == r && s < 2;
            size_32: return int'(addr) == r;
            default: return 1'b0;
        endcase
    endfunction

    task automatic update_model();
        logic hit;
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                for (int b = 0; b < 4; b++)
                    gpr_img[i][b] = '0;
                for (int s = 0; s < 3; s++) begin
                    sec_tag[i][s]  = '0;
                    sec_busy[i][s] = 1'b0;
                end
                mmx_img[i] = '0;
                mm_tag[i]  = '0;
                mm_busy[i] = 1'b0;
            end
            return;
        end
        if (wr_en) begin
            case (wr_size)
                size_8: begin
                    if (wr_addr < 4) gpr_img[wr_addr][0] = wr_data[7:0];
                    else gpr_img[wr_addr[1:0]][1] = wr_data[7:0]; // ah, ch, dh, bh
                end
                size_16: for (int b = 0; b < 2; b++) gpr_img[wr_addr][b] = wr_data[8*b +: 8];
                size_32: for (int b = 0; b < 4; b++) gpr_img[wr_addr][b] = wr_data[8*b +: 8];
                default: mmx_img[wr_addr] = wr_data;
            endcase
        end
        for (int i = 0; i < num_regs; i++) begin
            for (int s = 0; s < 3; s++) begin
                hit = dest && section_hit(rd_addr, rd_size, i, s);
                if (flush) sec_busy[i][s] = 1'b0;
                else if (hit) begin
                    sec_tag[i][s]  = new_tag;
                    sec_busy[i][s] = 1'b1;
                end else if (sec_tag[i][s] == bcast_tag) sec_busy[i][s] = 1'b0;
            end
            hit = dest && rd_size == size_64 && rd_addr == i;
            if (flush) mm_busy[i] = 1'b0;
            else if (hit) begin
                mm_tag[i]  = new_tag;
                mm_busy[i] = 1'b1;
            end else if (mm_tag[i] == bcast_tag) mm_busy[i] = 1'b0;
        end
    endtask

    task automatic expected_read();
        int r;
        int s;
        int nbytes;
        int nslots;
        exp_data = '0;
        exp_busy = '0;
        for (int k = 0; k < num_slots; k++)
            exp_tag[k] = '0;
        r = rd_addr;
        case (rd_size)
            size_8: begin
                s = (rd_addr < 4) ? 0 : 1;
                r = (rd_addr < 4) ? rd_addr : rd_addr - 4;
                exp_data[7:0] = gpr_img[r][s];
                exp_tag[0]    = sec_tag[r][s];
                exp_busy[0]   = sec_busy[r][s];
            end
            size_16, size_32: begin
                nbytes = (rd_size == size_16) ? 2 : 4;
                nslots = (rd_size == size_16) ? 2 : 3; // word covers lo and hi
                for (int b = 0; b < nbytes; b++)
                    exp_data[8*b +: 8] = gpr_img[r][b];
                for (int k = 0; k < nslots; k++) begin
                    exp_tag[k]  = sec_tag[r][k];
                    exp_busy[k] = sec_busy[r][k];
                end
            end
            default: begin
                exp_data    = mmx_img[r];
                exp_tag[0]  = mm_tag[r];
                exp_busy[0] = mm_busy[r];
            end
        endcase
    endtask

    task automatic report_mismatch(input string name, input data_t expv, input data_t actv);
        $display("ERROR: %s expected %h actual %h at %0t", name, expv, actv, $time);
        err_count++;
        $display("Testbench failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_outputs();
        expected_read();
        assert (rd_data === exp_data) else report_mismatch("rd_data", exp_data, rd_data);
        assert (rd_busy === exp_busy) else report_mismatch("rd_busy", exp_busy, rd_busy);
        assert (rd_tag0 === exp_tag[0]) else report_mismatch("rd_tag0", exp_tag[0], rd_tag0);
        assert (rd_tag1 === exp_tag[1]) else report_mismatch("rd_tag1", exp_tag[1], rd_tag1);
        assert (rd_tag2 === exp_tag[2]) else report_mismatch("rd_tag2", exp_tag[2], rd_tag2);
    endtask

    task automatic drive_random();
        logic d;
        tag_t t;
        d = ($urandom_range(3, 0) == 0);
        t = tag_t'($urandom);
        wr_en   <= $urandom_range(1, 0);
        wr_addr <= reg_addr_t'($urandom);
        wr_size <= size_e'($urandom_range(3, 0));
        wr_data <= {$urandom, $urandom};
        rd_addr <= reg_addr_t'($urandom);
        rd_size <= size_e'($urandom_range(3, 0));
        dest    <= d;
        new_tag <= t;
        flush   <= ($urandom_range(63, 0) == 0);
        // mostly broadcast a tag that was handed out lately
        if (recent_tags.size() > 0 && $urandom_range(3, 0) != 0)
            bcast_tag <= recent_tags[$urandom_range(recent_tags.size() - 1, 0)];
        else
            bcast_tag <= tag_t'($urandom);
        if (d) begin
            recent_tags.push_back(t);
            if (recent_tags.size() > 8) void'(recent_tags.pop_front());
        end
    endtask

    initial begin
        void'($urandom(32'hbde172ae));
        err_count = 0;
        clk       = 1'b0;
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_size   = size_8;
        wr_data   = '0;
        rd_addr   = '0;
        rd_size   = size_8;
        dest      = 1'b0;
        new_tag   = '0;
        bcast_tag = '0;
        flush     = 1'b0;
        for (int c = 0; c < rst_cycles; c++) begin
            @(posedge clk);
            update_model();
            if (c == rst_cycles - 1) rst <= 1'b0;
        end
        // read every size and address from the reset state
        for (int i = 0; i < sweep_cycles; i++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            rd_size <= size_e'(i / num_regs);
            rd_addr <= reg_addr_t'(i % num_regs);
        end
        for (int i = 0; i < num_cycles; i++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            drive_random();
        end
        @(negedge clk);
        check_outputs();
        if (err_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* test/regfile_props.sv */
`timescale 1ns/1ps

module regfile_props import regfile_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input size_e                rd_size,
    input data_t                rd_data,
    input logic [num_slots-1:0] rd_busy
);

    // nothing can be reserved straight out of reset
    a_reset_idle: assert property (@(posedge clk) rst |=> rd_busy == '0)
        else $error("busy bit set in the cycle after reset");

    a_byte_zext: assert property (@(posedge clk) disable iff (rst)
        rd_size == size_8 |-> rd_data[63:8] == '0)
        else $error("byte read not zero extended");

    a_word_zext: assert property (@(posedge clk) disable iff (rst)
        rd_size == size_16 |-> rd_data[63:16] == '0)
        else $error("word read not zero extended");

    // byte and mmx reads only use slot 0
    a_slot_single: assert property (@(posedge clk) disable iff (rst)
        (rd_size == size_8 || rd_size == size_64) |-> rd_busy[2:1] == '0)
        else $error("busy reported on an unused slot");

    a_slot_upper: assert property (@(posedge clk) disable iff (rst)
        rd_size == size_16 |-> !rd_busy[2])
        else $error("upper half busy reported on a word read");

endmodule

bind regfile_top regfile_props regfile_props_inst (
    .clk     (clk),
    .rst     (rst),
    .rd_size (rd_size),
    .rd_data (rd_data),
    .rd_busy (rd_busy)
);

/* design/regfile_top.sv */
`timescale 1ns/1ps

module regfile_top import regfile_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  reg_addr_t            wr_addr,
    input  size_e                wr_size,
    input  data_t                wr_data,
    input  reg_addr_t            rd_addr,
    input  size_e                rd_size,
    input  logic                 dest,
    input  tag_t                 new_tag,
    input  tag_t                 bcast_tag,
    input  logic                 flush,
    output data_t                rd_data,
    output logic [num_slots-1:0] rd_busy,
    output tag_t                 rd_tag0,
    output tag_t                 rd_tag1,
    output tag_t                 rd_tag2
);

    access_if acc ();
    read_if   gpr_rd ();
    read_if   mmx_rd ();

    assign acc.wr_en     = wr_en;
    assign acc.wr_addr   = wr_addr;
    assign acc.wr_size   = wr_size;
    assign acc.wr_data   = wr_data;
    assign acc.rd_addr   = rd_addr;
    assign acc.rd_size   = rd_size;
    assign acc.dest      = dest;
    assign acc.new_tag   = new_tag;
    assign acc.bcast_tag = bcast_tag;
    assign acc.flush     = flush;

    gpr_bank gpr_bank_inst (
        .clk (clk),
        .rst (rst),
        .acc (acc.bank),
        .rd  (gpr_rd.bank)
    );

    mmx_bank mmx_bank_inst (
        .clk (clk),
        .rst (rst),
        .acc (acc.bank),
        .rd  (mmx_rd.bank)
    );

    // the bank outside its size range drives zeros, so OR merges them
    assign rd_data = gpr_rd.rd_data | mmx_rd.rd_data;
    assign rd_busy = gpr_rd.rd_busy | mmx_rd.rd_busy;
    assign rd_tag0 = gpr_rd.rd_tag0 | mmx_rd.rd_tag0;
    assign rd_tag1 = gpr_rd.rd_tag1 | mmx_rd.rd_tag1;
    assign rd_tag2 = gpr_rd.rd_tag2 | mmx_rd.rd_tag2;

endmodule

/* design/mmx_bank.sv */
`timescale 1ns/1ps

module mmx_bank import regfile_pkg::*; (
    input logic   clk,
    input logic   rst,
    access_if.bank acc,
    read_if.bank   rd
);

    data_t mm_q [num_regs];

    logic                wr_hit;
    logic                rd_hit;
    logic [num_regs-1:0] set_sel;

    tag_t mm_tag  [num_regs];
    logic mm_busy [num_regs];

    assign wr_hit = acc.wr_en && (acc.wr_size == size_64);
    assign rd_hit = (acc.rd_size == size_64);

    always_comb begin
        for (int i = 0; i < num_regs; i++)
            set_sel[i] = acc.dest && rd_hit && (acc.rd_addr == i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++)
                mm_q[i] <= '0;
        end else if (wr_hit) begin
            mm_q[acc.wr_addr] <= acc.wr_data;
        end
    end

    // one tag per mm register, whole register renamed at once
    for (genvar i = 0; i < num_regs; i++) begin : g_reg
        tag_slot tag_slot_inst (
            .clk       (clk),
            .rst       (rst),
            .set       (set_sel[i]),
            .new_tag   (acc.new_tag),
            .bcast_tag (acc.bcast_tag),
            .flush     (acc.flush),
            .tag       (mm_tag[i]),
            .busy      (mm_busy[i])
        );
    end

    assign rd.rd_data = rd_hit ? mm_q[acc.rd_addr] : '0;
    assign rd.rd_tag0 = rd_hit ? mm_tag[acc.rd_addr] : '0;
    assign rd.rd_busy = {{(num_slots-1){1'b0}}, rd_hit && mm_busy[acc.rd_addr]};
    assign rd.rd_tag1 = '0; // only slot 0 used
    assign rd.rd_tag2 = '0;

endmodule

/* design/gpr_bank.sv */
`timescale 1ns/1ps

module gpr_bank import regfile_pkg::*; (
    input logic   clk,
    input logic   rst,
    access_if.bank acc,
    read_if.bank   rd
);

    // section storage, index 0 lo byte, 1 hi byte, 2 upper half
    logic [7:0]  lo_q [num_regs];
    logic [7:0]  hi_q [num_regs];
    logic [15:0] up_q [num_regs];

    logic [2:0] wr_sel  [num_regs];
    logic [2:0] set_sel [num_regs];

    tag_t slot_tag  [num_regs][num_slots];
    logic slot_busy [num_regs][num_slots];

    logic [7:0]  hi_d;
    reg_addr_t   rd_reg;

    data_t                rd_data_c;
    logic [num_slots-1:0] rd_busy_c;
    tag_t                 rd_tag_c [num_slots];

    // sections of register idx covered by an access at addr/size
    function automatic logic [2:0] sect_mask(input reg_addr_t addr, input size_e size,
                                             input int idx);
        logic [2:0] mask;
        mask = '0;
        case (size)
            size_8: begin
                if (!addr[2] && addr == idx)
                    mask = 3'b001;
                else if (addr[2] && addr[1:0] == idx)
                    mask = 3'b010; // ah/ch/dh/bh
            end
            size_16: if (addr == idx) mask = 3'b011;
            size_32: if (addr == idx) mask = 3'b111;
            default: mask = '0;
        endcase
        return mask;
    endfunction

    always_comb begin
        for (int i = 0; i < num_regs; i++) begin
            wr_sel[i]  = acc.wr_en ? sect_mask(acc.wr_addr, acc.wr_size, i) : 3'b000;
            set_sel[i] = acc.dest  ? sect_mask(acc.rd_addr, acc.rd_size, i) : 3'b000;
        end
    end

    // a byte write to the high section takes the low data byte
    assign hi_d = (acc.wr_size == size_8) ? acc.wr_data[7:0] : acc.wr_data[15:8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                lo_q[i] <= '0;
                hi_q[i] <= '0;
                up_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (wr_sel[i][0]) lo_q[i] <= acc.wr_data[7:0];
                if (wr_sel[i][1]) hi_q[i] <= hi_d;
                if (wr_sel[i][2]) up_q[i] <= acc.wr_data[31:16];
            end
        end
    end

    for (genvar i = 0; i < num_regs; i++) begin : g_reg
        for (genvar j = 0; j < num_slots; j++) begin : g_sect
            tag_slot tag_slot_inst (
                .clk       (clk),
                .rst       (rst),
                .set       (set_sel[i][j]),
                .new_tag   (acc.new_tag),
                .bcast_tag (acc.bcast_tag),
                .flush     (acc.flush),
                .tag       (slot_tag[i][j]),
                .busy      (slot_busy[i][j])
            );
        end
    end

    // byte reads at 4..7 land on registers 0..3
    assign rd_reg = (acc.rd_size == size_8) ? {1'b0, acc.rd_addr[1:0]} : acc.rd_addr;

    always_comb begin
        rd_data_c = '0;
        rd_busy_c = '0;
        for (int j = 0; j < num_slots; j++)
            rd_tag_c[j] = '0;
        case (acc.rd_size)
            size_8: begin
                if (acc.rd_addr[2]) begin
                    rd_data_c[7:0] = hi_q[rd_reg];
                    rd_tag_c[0]    = slot_tag[rd_reg][1];
                    rd_busy_c[0]   = slot_busy[rd_reg][1];
                end else begin
                    rd_data_c[7:0] = lo_q[rd_reg];
                    rd_tag_c[0]    = slot_tag[rd_reg][0];
                    rd_busy_c[0]   = slot_busy[rd_reg][0];
                end
            end
            size_16, size_32: begin
                rd_data_c[15:0] = {hi_q[rd_reg], lo_q[rd_reg]};
                for (int j = 0; j < 2; j++) begin
                    rd_tag_c[j]  = slot_tag[rd_reg][j];
                    rd_busy_c[j] = slot_busy[rd_reg][j];
                end
                if (acc.rd_size == size_32) begin
                    rd_data_c[31:16] = up_q[rd_reg];
                    rd_tag_c[2]      = slot_tag[rd_reg][2];
                    rd_busy_c[2]     = slot_busy[rd_reg][2];
                end
            end
            default: ; // mmx access
        endcase
    end

    assign rd.rd_data = rd_data_c;
    assign rd.rd_busy = rd_busy_c;
    assign rd.rd_tag0 = rd_tag_c[0];
    assign rd.rd_tag1 = rd_tag_c[1];
    assign rd.rd_tag2 = rd_tag_c[2];

endmodule

/* design/tag_slot.sv */
`timescale 1ns/1ps

module tag_slot import regfile_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic set,
    input  tag_t new_tag,
    input  tag_t bcast_tag,
    input  logic flush,
    output tag_t tag,
    output logic busy
);

    logic hit;

    assign hit = (tag == bcast_tag); // broadcast compare, ungated

    always_ff @(posedge clk) begin
        if (rst) begin
            tag  <= '0;
            busy <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0; // tag kept
        end else if (set) begin
            tag  <= new_tag;
            busy <= 1'b1;
        end else if (hit) begin
            busy <= 1'b0;
        end
    end

endmodule

/* design/regfile_if.sv */
`timescale 1ns/1ps

// write, read address, reservation and broadcast controls shared by both banks
interface access_if import regfile_pkg::*; ();

    logic      wr_en;
    reg_addr_t wr_addr;
    size_e     wr_size;
    data_t     wr_data;
    reg_addr_t rd_addr;
    size_e     rd_size;
    logic      dest;      // reserve the read target
    tag_t      new_tag;
    tag_t      bcast_tag;
    logic      flush;

    modport bank (
        input wr_en, wr_addr, wr_size, wr_data,
        input rd_addr, rd_size, dest, new_tag, bcast_tag, flush
    );

    modport top (
        output wr_en, wr_addr, wr_size, wr_data,
        output rd_addr, rd_size, dest, new_tag, bcast_tag, flush
    );

endinterface

// formatted read result of one bank
interface read_if import regfile_pkg::*; ();

    data_t                rd_data;
    logic [num_slots-1:0] rd_busy;
    tag_t                 rd_tag0;
    tag_t                 rd_tag1;
    tag_t                 rd_tag2;

    modport bank (
        output rd_data, rd_busy, rd_tag0, rd_tag1, rd_tag2
    );

    modport top (
        input rd_data, rd_busy, rd_tag0, rd_tag1, rd_tag2
    );

endinterface

/* design/regfile_pkg.sv */
package regfile_pkg;

    // bank geometry
    localparam int num_regs  = 8;
    localparam int num_slots = 3; // lo byte / mmx, hi byte, upper half

    // datapath widths
    localparam int tag_w  = 7;
    localparam int data_w = 64;

    typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
    typedef logic [tag_w-1:0]            tag_t;
    typedef logic [data_w-1:0]           data_t;

    // access width, size_64 selects the mmx bank
    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2,
        size_64 = 2'd3
    } size_e;

endpackage
